// ==== logic/mul_arith_pkg.sv ====
// Multiplier arithmetic types
package mul_arith_pkg;

	typedef logic [31:0] operand_t;
	typedef logic [63:0] product_t;

	// booth row, 33-bit value plus inverted sign on top.
	typedef logic [33:0] pp_row_t;

	typedef logic [63:0] csa_row_t;

	localparam int NUM_BOOTH_ROWS = 16;

	// booth rows, correction row, carry-in/sign row.
	localparam int NUM_TREE_ROWS = NUM_BOOTH_ROWS + 2;

	// cancels the 2^33 bias of every booth row, bits 63:32 of the constant.
	localparam logic [31:0] SIGN_EXT_PATTERN = 32'h5555_5556;

	typedef struct packed {
		pp_row_t [NUM_BOOTH_ROWS-1:0] booth;
		operand_t corr;                          // unsigned multiplier msb fixup.
		logic [NUM_BOOTH_ROWS-1:0] neg_cin;      // +1 for negative digits.
		logic [31:0] sign_ext;
	} pp_array_t;

	typedef struct packed {
		csa_row_t carry;
		csa_row_t sum;
	} csa_pair_t;

	// 3:2 compressor, carry returned unshifted.
	function automatic csa_pair_t csa_row(
		input csa_row_t a,
		input csa_row_t b,
		input csa_row_t c
	);
		csa_pair_t p;
		p.sum = a ^ b ^ c;
		p.carry = (a & b) | (b & c) | (a & c);
		return p;
	endfunction

endpackage

// ==== logic/mul_flow_pkg.sv ====
// Multiplier flow control types
package mul_flow_pkg;

	typedef struct packed {
		mul_arith_pkg::operand_t multiplicand;
		mul_arith_pkg::operand_t multiplier;
		logic is_signed;
	} mul_req_t;

	// result slots, also the request credits held after reset.
	localparam int QUEUE_DEPTH = 4;

	// booth, tree and final add registers.
	localparam int PIPE_STAGES = 3;

	typedef logic [2:0] credit_cnt_t;

	typedef logic [$clog2(QUEUE_DEPTH)-1:0] queue_ptr_t;

endpackage

// ==== logic/booth_recoder.sv ====
// Radix-4 Booth partial products
`timescale 1ns/1ps

module booth_recoder (
	input logic clk,
	input logic reset,
	input logic req_valid,
	input mul_flow_pkg::mul_req_t req,
	output logic pp_valid,
	output mul_arith_pkg::pp_array_t pp
);

	import mul_arith_pkg::*;

	pp_array_t pp_d;

	// one digit worth of multiplicand, encoded so the row sum is value + 2^33.
	function automatic pp_row_t booth_row(
		input logic [2:0] digit,
		input operand_t a,
		input logic se
	);
		case (digit)
			3'b001, 3'b010: return {~se, se, a};          // +x.
			3'b011: return {~se, a, 1'b0};                // +2x.
			3'b100: return {se, ~a, 1'b1};                // -2x, ones complement.
			3'b101, 3'b110: return {se, ~se, ~a};         // -x.
			default: return {2'b10, 32'b0};               // zero.
		endcase
	endfunction

	always_comb begin
		logic se;
		logic [32:0] mext;
		se = req.is_signed & req.multiplicand[31];
		mext = {req.multiplier, 1'b0}; // implicit zero below bit 0.
		for (int i = 0; i < NUM_BOOTH_ROWS; i++) begin
			pp_d.booth[i] = booth_row(mext[2*i+2 -: 3], req.multiplicand, se);
			pp_d.neg_cin[i] = mext[2*i+2] & ~(mext[2*i+1] & mext[2*i]);
		end

		// booth reads bit 31 as a sign, add it back as weight 2^32.
		if (!req.is_signed && req.multiplier[31]) begin
			pp_d.corr = req.multiplicand;
		end else begin
			pp_d.corr = '0;
		end
		pp_d.sign_ext = SIGN_EXT_PATTERN;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pp_valid <= 1'b0;
		end else begin
			pp_valid <= req_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid) begin
			pp <= pp_d;
		end
	end

endmodule

// ==== logic/csa_reduce.sv ====
// Carry-save tree and final adder
`timescale 1ns/1ps

module csa_reduce (
	input logic clk,
	input logic reset,
	input logic pp_valid,
	input mul_arith_pkg::pp_array_t pp,
	output logic prod_valid,
	output mul_arith_pkg::product_t prod
);

	import mul_arith_pkg::*;

	csa_row_t rows0 [NUM_TREE_ROWS];
	csa_row_t rows1 [12];
	csa_row_t rows2 [8];
	csa_row_t rows3 [6];
	csa_row_t rows4 [4];
	csa_row_t rows5 [3];
	csa_pair_t tree_out;
	csa_pair_t tree_q;
	logic tree_valid;

	// compressor with the carry row already aligned.
	function automatic csa_pair_t compress(
		input csa_row_t a,
		input csa_row_t b,
		input csa_row_t c
	);
		csa_pair_t p;
		p = csa_row(a, b, c);
		p.carry = {p.carry[62:0], 1'b0};
		return p;
	endfunction

	// align booth rows to their digit weight.
	always_comb begin
		logic [31:0] cin_row;
		cin_row = '0;
		for (int i = 0; i < NUM_BOOTH_ROWS; i++) begin
			rows0[i] = csa_row_t'(pp.booth[i]) << (2 * i);
			cin_row[2*i] = pp.neg_cin[i];
		end
		rows0[NUM_BOOTH_ROWS] = {pp.corr, 32'b0};
		rows0[NUM_BOOTH_ROWS + 1] = {pp.sign_ext, cin_row}; // no overlap between halves.
	end

	// 18 -> 12 -> 8 -> 6 -> 4 -> 3 -> 2.
	always_comb begin
		csa_pair_t p;
		for (int k = 0; k < 6; k++) begin
			p = compress(rows0[3*k], rows0[3*k+1], rows0[3*k+2]);
			rows1[2*k] = p.sum;
			rows1[2*k+1] = p.carry;
		end
		for (int k = 0; k < 4; k++) begin
			p = compress(rows1[3*k], rows1[3*k+1], rows1[3*k+2]);
			rows2[2*k] = p.sum;
			rows2[2*k+1] = p.carry;
		end
		for (int k = 0; k < 2; k++) begin
			p = compress(rows2[3*k], rows2[3*k+1], rows2[3*k+2]);
			rows3[2*k] = p.sum;
			rows3[2*k+1] = p.carry;
		end
		rows3[4] = rows2[6]; // pass through.
		rows3[5] = rows2[7];
		for (int k = 0; k < 2; k++) begin
			p = compress(rows3[3*k], rows3[3*k+1], rows3[3*k+2]);
			rows4[2*k] = p.sum;
			rows4[2*k+1] = p.carry;
		end
		p = compress(rows4[0], rows4[1], rows4[2]);
		rows5[0] = p.sum;
		rows5[1] = p.carry;
		rows5[2] = rows4[3];
		tree_out = compress(rows5[0], rows5[1], rows5[2]);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			tree_valid <= 1'b0;
			prod_valid <= 1'b0;
		end else begin
			tree_valid <= pp_valid;
			prod_valid <= tree_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (pp_valid) begin
			tree_q <= tree_out;
		end
		if (tree_valid) begin
			prod <= tree_q.sum + tree_q.carry; // wraps mod 2^64.
		end
	end

endmodule

// ==== logic/result_queue.sv ====
// Result queue with credit flow
`timescale 1ns/1ps

module result_queue (
	input logic clk,
	input logic reset,
	input logic prod_valid,
	input mul_arith_pkg::product_t prod,
	input logic rsp_credit,
	output logic rsp_valid,
	output mul_arith_pkg::product_t rsp_product,
	output logic req_credit
);

	import mul_arith_pkg::*;
	import mul_flow_pkg::*;

	product_t q_mem [QUEUE_DEPTH];
	queue_ptr_t wr_ptr;
	queue_ptr_t rd_ptr;
	credit_cnt_t q_count;
	credit_cnt_t rsp_credits;    // held consumer credits.
	logic pop;

	// one result per cycle while data and a credit are both present.
	assign pop = (q_count != '0) && (rsp_credits != '0);

	assign rsp_valid = pop;
	assign rsp_product = q_mem[rd_ptr];
	assign req_credit = pop; // freed slot goes back to the producer.

	always_ff @(posedge clk) begin
		if (prod_valid) begin
			q_mem[wr_ptr] <= prod;
		end
	end

	// pointers wrap on their own, depth is a power of two.
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_count <= '0;
			rsp_credits <= '0;
		end else begin
			if (prod_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			q_count <= q_count + credit_cnt_t'(prod_valid) - credit_cnt_t'(pop);
			rsp_credits <= rsp_credits + credit_cnt_t'(rsp_credit) - credit_cnt_t'(pop);
		end
	end

endmodule

// ==== logic/mdu_mul_top.sv ====
// Pipelined Booth multiplier top
`timescale 1ns/1ps

module mdu_mul_top (
	input logic clk,
	input logic reset,
	input logic req_valid,
	input mul_flow_pkg::mul_req_t req,
	output logic req_credit,
	output logic rsp_valid,
	output mul_arith_pkg::product_t rsp_product,
	input logic rsp_credit
);

	import mul_arith_pkg::*;

	logic pp_valid;
	pp_array_t pp;
	logic prod_valid;
	product_t prod;

	booth_recoder i_booth_recoder (
		.clk       (clk),
		.reset     (reset),
		.req_valid (req_valid),
		.req       (req),
		.pp_valid  (pp_valid),
		.pp        (pp)
	);

	csa_reduce i_csa_reduce (
		.clk        (clk),
		.reset      (reset),
		.pp_valid   (pp_valid),
		.pp         (pp),
		.prod_valid (prod_valid),
		.prod       (prod)
	);

	result_queue i_result_queue (
		.clk         (clk),
		.reset       (reset),
		.prod_valid  (prod_valid),
		.prod        (prod),
		.rsp_credit  (rsp_credit),
		.rsp_valid   (rsp_valid),
		.rsp_product (rsp_product),
		.req_credit  (req_credit)
	);

endmodule

// ==== bench/mdu_mul_asserts.sv ====
// Result queue assertions
`timescale 1ns/1ps

module mdu_mul_asserts (
	input logic clk,
	input logic reset,
	input logic prod_valid,
	input mul_flow_pkg::credit_cnt_t q_count,
	input mul_flow_pkg::credit_cnt_t rsp_credits,
	input logic rsp_credit,
	input logic rsp_valid,
	input logic req_credit
);

	import mul_flow_pkg::*;

	int fail_count;
	int held_credits;    // granted by the consumer, not yet spent.
	int held_results;    // written into the queue, not yet sent.

	initial fail_count = 0;

	always_ff @(posedge clk) begin
		if (reset) begin
			held_credits <= 0;
			held_results <= 0;
		end else begin
			held_credits <= held_credits + int'(rsp_credit) - int'(rsp_valid);
			held_results <= held_results + int'(prod_valid) - int'(rsp_valid);
		end
	end

	no_write_when_full: assert property (
		@(posedge clk) disable iff (reset) prod_valid |-> (q_count < QUEUE_DEPTH)
	) else begin
		$error("result queue written while full");
		fail_count++;
	end

	// a response always spends a credit the consumer granted.
	no_rsp_without_credit: assert property (
		@(posedge clk) disable iff (reset) rsp_valid |-> (held_credits > 0)
	) else begin
		$error("rsp_valid raised with zero output credits");
		fail_count++;
	end

	credit_follows_rsp: assert property (
		@(posedge clk) disable iff (reset)
			(req_credit == rsp_valid) && (!req_credit || held_results > 0)
	) else begin
		$error("req_credit differs from rsp_valid or frees no stored result");
		fail_count++;
	end

	empty_after_reset: assert property (
		@(posedge clk) reset |=> (q_count == '0 && rsp_credits == '0 && !rsp_valid && !req_credit)
	) else begin
		$error("result queue not empty after reset");
		fail_count++;
	end

endmodule

bind result_queue mdu_mul_asserts i_asserts (
	.clk         (clk),
	.reset       (reset),
	.prod_valid  (prod_valid),
	.q_count     (q_count),
	.rsp_credits (rsp_credits),
	.rsp_credit  (rsp_credit),
	.rsp_valid   (rsp_valid),
	.req_credit  (req_credit)
);

// ==== bench/mdu_mul_tb.sv ====
// Multiplier trace testbench
`timescale 1ns/1ps

module mdu_mul_tb;

	import mul_arith_pkg::*;
	import mul_flow_pkg::*;

	localparam int INIT_RSP_CREDITS = 2;
	localparam int MAX_OUTSTANDING = 4; // keeps the unit's credit counter in range.
	localparam int STALL_LIMIT = 200;
	localparam int DRAIN_CYCLES = 10;

	logic clk;
	logic reset;
	logic req_valid;
	mul_req_t req;
	logic req_credit;
	logic rsp_valid;
	product_t rsp_product;
	logic rsp_credit;

	operand_t tr_a [$];
	operand_t tr_b [$];
	logic tr_signed [$];
	product_t tr_prod [$];
	int tr_delay [$];

	product_t exp_q [$];
	int issue_q [$];

	int cycle;
	int sent;
	int rsp_seen;
	int granted;
	int prod_credits;
	int init_left;
	int grant_idx;
	int wait_cnt;
	int last_progress;

	mdu_mul_top i_dut (
		.clk         (clk),
		.reset       (reset),
		.req_valid   (req_valid),
		.req         (req),
		.req_credit  (req_credit),
		.rsp_valid   (rsp_valid),
		.rsp_product (rsp_product),
		.rsp_credit  (rsp_credit)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("MISMATCH time=%0t signal=%s expected=%h actual=%h",
				$time, name, expected, actual));
		end
	endtask

	task automatic load_trace();
		int fd;
		int n;
		string line;
		operand_t a;
		operand_t b;
		int s;
		product_t p;
		int d;
		fd = $fopen("bench/mdu_mul_trace.txt", "r");
		if (fd == 0) begin
			stop_with_failure("cannot open the trace file bench/mdu_mul_trace.txt");
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#") begin
				continue; // comment or blank line.
			end
			n = $sscanf(line, "%h %h %d %h %d", a, b, s, p, d);
			if (n != 5) begin
				stop_with_failure($sformatf("malformed trace line: %s", line));
			end
			tr_a.push_back(a);
			tr_b.push_back(b);
			tr_signed.push_back(s[0]);
			tr_prod.push_back(p);
			tr_delay.push_back(d);
		end
		$fclose(fd);
		if (tr_a.size() == 0) begin
			stop_with_failure("the trace file holds no operations");
		end
	endtask

	// trace delay plus a small random stretch.
	task automatic load_grant_delay();
		wait_cnt = tr_delay[grant_idx] + int'($urandom % 3);
	endtask

	task automatic drive_request();
		if (sent < tr_a.size() && prod_credits > 0) begin
			req_valid = 1'b1;
			req.multiplicand = tr_a[sent];
			req.multiplier = tr_b[sent];
			req.is_signed = tr_signed[sent];
			exp_q.push_back(tr_prod[sent]);
			issue_q.push_back(cycle + 1); // counted from the accepting edge.
			prod_credits--;
			sent++;
		end else begin
			req_valid = 1'b0;
		end
	endtask

	task automatic drive_credit();
		rsp_credit = 1'b0;
		if (init_left > 0) begin
			rsp_credit = 1'b1; // opening burst.
			init_left--;
			granted++;
		end else if (grant_idx < tr_delay.size()) begin
			if (wait_cnt > 0) begin
				wait_cnt--;
			end else if (granted - rsp_seen < MAX_OUTSTANDING) begin
				rsp_credit = 1'b1;
				granted++;
				grant_idx++;
				if (grant_idx < tr_delay.size()) begin
					load_grant_delay();
				end
			end
		end
	endtask

	// outputs are settled at the falling edge.
	task automatic step_cycle();
		logic rv;
		logic rc;
		product_t rp;
		@(negedge clk);
		cycle++;
		rv = rsp_valid;
		rc = req_credit;
		rp = rsp_product;
		if (i_dut.i_result_queue.i_asserts.fail_count != 0) begin
			stop_with_failure("a bound assertion on the result queue failed");
		end
		check_value("req_credit", 64'(rv), 64'(rc));
		if (rv) begin
			rsp_seen++;
			if (rsp_seen > granted) begin
				stop_with_failure("more responses were sent than credits were granted");
			end
			if (exp_q.size() == 0) begin
				stop_with_failure("a response arrived with no request outstanding");
			end
			check_value("rsp_product", exp_q.pop_front(), rp);
			if (cycle - issue_q.pop_front() < PIPE_STAGES) begin
				stop_with_failure("a response arrived sooner than the pipeline depth allows");
			end
			last_progress = cycle;
		end
		if (rc) begin
			prod_credits++;
			if (prod_credits > QUEUE_DEPTH) begin
				stop_with_failure("the producer holds more request credits than queue slots");
			end
		end
		drive_request();
		drive_credit();
	endtask

	initial begin
		void'($urandom(32'h351b));
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		rsp_credit = 1'b0;
		cycle = 0;
		sent = 0;
		rsp_seen = 0;
		granted = 0;
		prod_credits = QUEUE_DEPTH;
		init_left = INIT_RSP_CREDITS;
		grant_idx = 0;
		last_progress = 0;
		load_trace();
		load_grant_delay();

		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// idle unit stays quiet.
		repeat (3) begin
			@(negedge clk);
			check_value("rsp_valid", 64'd0, 64'(rsp_valid));
			check_value("req_credit", 64'd0, 64'(req_credit));
		end

		while (rsp_seen < tr_a.size()) begin
			step_cycle();
			if (cycle - last_progress > STALL_LIMIT) begin
				stop_with_failure("timed out waiting for the next response");
			end
		end

		// spare credits expose any duplicate.
		repeat (DRAIN_CYCLES) begin
			step_cycle();
		end

		if (i_dut.i_result_queue.i_asserts.fail_count == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			stop_with_failure("a bound assertion on the result queue failed");
		end
	end

endmodule

// ==== mdu_mul.f ====
logic/mul_arith_pkg.sv
logic/mul_flow_pkg.sv
logic/booth_recoder.sv
logic/csa_reduce.sv
logic/result_queue.sv
logic/mdu_mul_top.sv
bench/mdu_mul_asserts.sv
bench/mdu_mul_tb.sv

// ==== bench/mdu_mul_trace.txt ====
# multiplicand multiplier signed expected_product credit_delay
# hex, hex, 0 or 1, 64-bit hex, cycles before the next response credit
00000003 00000005 0 000000000000000f 0
ffffffff ffffffff 0 fffffffe00000001 0
00000002 80000000 0 0000000100000000 1
12345678 80000001 0 091a2b3c12345678 0
80000000 ffffffff 0 7fffffff80000000 0
80000000 80000000 1 4000000000000000 12
80000000 ffffffff 1 0000000080000000 0
ffffffff ffffffff 1 0000000000000001 0
ffffffff 00000002 1 fffffffffffffffe 2
7fffffff 7fffffff 1 3fffffff00000001 0
7fffffff 80000000 1 c000000080000000 0
80000000 80000000 0 4000000000000000 15
ffffffff 00000001 0 00000000ffffffff 0
00010000 00010000 0 0000000100000000 3
ffff0000 0000ffff 1 ffffffff00010000 0
00000000 deadbeef 0 0000000000000000 0
0000000a fffffff6 1 ffffffffffffff9c 1
80000000 00000001 1 ffffffff80000000 0
0000ffff 0000ffff 0 00000000fffe0001 8
00000007 fffffffd 1 ffffffffffffffeb 0
12345678 00000010 0 0000000123456780 0
aaaaaaaa 00000003 0 00000001fffffffe 0
87654321 00000002 1 ffffffff0eca8642 4
87654321 00000002 0 000000010eca8642 0
00000001 ffffffff 1 ffffffffffffffff 0
40000000 40000000 1 1000000000000000 0
